// File: logic/cache_cfg.svh
/*
 Address split and array sizes for the 4-way data cache.
 The fields must add up to 32 bits and CACHE_SETS must equal 2**CACHE_INDEX_BITS.
*/
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// address fields, msb to lsb
`define CACHE_TAG_BITS   24
`define CACHE_INDEX_BITS 4
`define CACHE_WORD_BITS  2
`define CACHE_BYTE_BITS  2

// array geometry
`define CACHE_WAYS       4
`define CACHE_SETS       16
`define CACHE_LINE_WORDS 4

// data path
`define CACHE_DATA_BITS  32

`endif

// File: logic/cache_pkg.sv
/*
 Operation and access-width encodings plus the field types of the cache.
 mem_width_t follows the RV32I load/store funct3 values.
*/
`include "cache_cfg.svh"

package cache_pkg;

    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2,
        op_fill  = 2'd3
    } cache_op_t;

    typedef enum logic [2:0] {
        width_b  = 3'b000,
        width_h  = 3'b001,
        width_w  = 3'b010,
        width_bu = 3'b100,
        width_hu = 3'b101
    } mem_width_t;

    typedef logic [`CACHE_TAG_BITS-1:0]     tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0]   set_index_t;
    typedef logic [`CACHE_WAYS-1:0]         way_onehot_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_index_t;
    typedef logic [`CACHE_DATA_BITS-1:0]    word_t;

endpackage

// File: logic/byte_lane_unit.sv
/*
 Load lane extraction with RV32I extension, and store merge into the old word.
 No alignment check; a half access uses only byte_offset[1].
*/
`timescale 1ns/10ps
`include "cache_cfg.svh"

module byte_lane_unit (
    input  cache_pkg::cache_op_t        op,
    input  cache_pkg::mem_width_t       width,
    input  logic [`CACHE_BYTE_BITS-1:0] byte_offset,
    input  cache_pkg::word_t            old_word,
    input  cache_pkg::word_t            wdata,
    output cache_pkg::word_t            load_data,
    output cache_pkg::word_t            wr_word
);

    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;
    cache_pkg::word_t merged;

    assign ld_byte = old_word[{byte_offset, 3'b000} +: 8];
    assign ld_half = byte_offset[1] ? old_word[31:16] : old_word[15:0];

    always_comb begin
        case (width)
            cache_pkg::width_b:  load_data = {{24{ld_byte[7]}}, ld_byte};
            cache_pkg::width_h:  load_data = {{16{ld_half[15]}}, ld_half};
            cache_pkg::width_bu: load_data = {24'b0, ld_byte};
            cache_pkg::width_hu: load_data = {16'b0, ld_half};
            default:             load_data = old_word;  // word, no extension
        endcase
    end

    // sign bit of funct3 means nothing for a store
    always_comb begin
        merged = old_word;
        case (width)
            cache_pkg::width_b, cache_pkg::width_bu: begin
                merged[{byte_offset, 3'b000} +: 8] = wdata[7:0];
            end
            cache_pkg::width_h, cache_pkg::width_hu: begin
                merged[{byte_offset[1], 4'b0000} +: 16] = wdata[15:0];
            end
            default: merged = wdata;
        endcase
    end

    assign wr_word = (op == cache_pkg::op_fill) ? wdata : merged;  // fill writes whole word

endmodule

// File: logic/data_store.sv
/*
 Data word array, 16 sets x 4 ways x 4 words.
 Combinational read of one word, single-way write on the clock edge, no reset.
*/
`timescale 1ns/10ps
`include "cache_cfg.svh"

module data_store (
    input  logic                        clk,
    input  cache_pkg::set_index_t       set_index,
    input  logic [`CACHE_WORD_BITS-1:0] word_offset,
    input  cache_pkg::way_index_t       target_way,
    input  logic                        data_we,
    input  cache_pkg::word_t            wr_word,
    output cache_pkg::word_t            rd_word
);

    localparam int DEPTH = `CACHE_SETS * `CACHE_WAYS * `CACHE_LINE_WORDS;
    localparam int ADDR_BITS = $clog2(DEPTH);

    cache_pkg::word_t       mem [DEPTH-1:0];
    logic [ADDR_BITS-1:0]   word_addr;

    assign word_addr = {set_index, target_way, word_offset};  // set | way | word
    assign rd_word   = mem[word_addr];

    always_ff @(posedge clk) begin
        if (data_we) begin
            mem[word_addr] <= wr_word;
        end
    end

endmodule

// File: logic/tag_store.sv
/*
 Tag, valid and dirty arrays with a compare on every way of the indexed set.
 Reset clears valid and dirty only; tags stay undefined until filled.
*/
`timescale 1ns/10ps
`include "cache_cfg.svh"

module tag_store (
    input  logic                   clk,
    input  logic                   reset,
    input  cache_pkg::set_index_t  set_index,
    input  cache_pkg::tag_t        addr_tag,
    input  cache_pkg::way_index_t  target_way,
    input  logic                   tag_we,
    input  logic                   dirty_set,
    output cache_pkg::way_onehot_t hit_ways,
    output cache_pkg::way_onehot_t valid_ways,
    output logic                   sel_valid,
    output logic                   sel_dirty,
    output cache_pkg::tag_t        sel_tag
);

    cache_pkg::tag_t        tag_mem [`CACHE_SETS-1:0][`CACHE_WAYS-1:0];
    cache_pkg::way_onehot_t valid_q [`CACHE_SETS-1:0];
    cache_pkg::way_onehot_t dirty_q [`CACHE_SETS-1:0];
    cache_pkg::way_onehot_t dirty_ways;

    assign valid_ways = valid_q[set_index];
    assign dirty_ways = dirty_q[set_index];

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_cmp
        assign hit_ways[w] = valid_ways[w] && (tag_mem[set_index][w] == addr_tag);
    end

    // fields of the way being hit or replaced
    assign sel_valid = valid_ways[target_way];
    assign sel_dirty = dirty_ways[target_way];
    assign sel_tag   = tag_mem[set_index][target_way];

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[set_index][target_way] <= addr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (tag_we) begin  // fill, line now clean
                valid_q[set_index][target_way] <= 1'b1;
                dirty_q[set_index][target_way] <= 1'b0;
            end
            if (dirty_set) begin
                dirty_q[set_index][target_way] <= 1'b1;
            end
        end
    end

endmodule

// File: logic/plru_tree.sv
/*
 Tree pseudo-LRU, 3 bits per set. bit 0 picks the pair, bit 2 ways 0/1, bit 1 ways 2/3.
 An invalid way always wins over the tree, lowest number first.
*/
`timescale 1ns/10ps
`include "cache_cfg.svh"

module plru_tree (
    input  logic                   clk,
    input  logic                   reset,
    input  cache_pkg::set_index_t  set_index,
    input  cache_pkg::way_onehot_t valid_ways,
    input  logic                   touch,
    input  cache_pkg::way_index_t  target_way,
    output cache_pkg::way_index_t  victim_way
);

    logic [2:0] tree_q [`CACHE_SETS-1:0];
    logic [2:0] tree;
    logic [2:0] tree_next;

    assign tree = tree_q[set_index];

    always_comb begin
        if (&valid_ways) begin
            if (!tree[0]) begin
                victim_way = tree[2] ? 2'd1 : 2'd0;
            end else begin
                victim_way = tree[1] ? 2'd3 : 2'd2;
            end
        end else begin
            victim_way = '0;
            for (int i = `CACHE_WAYS - 1; i >= 0; i--) begin
                if (!valid_ways[i]) victim_way = cache_pkg::way_index_t'(i);
            end
        end
    end

    // point every level on the path away from the accessed way
    always_comb begin
        tree_next    = tree;
        tree_next[0] = ~target_way[1];
        if (target_way[1]) begin
            tree_next[1] = ~target_way[0];
        end else begin
            tree_next[2] = ~target_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            tree_q[set_index] <= tree_next;
        end
    end

endmodule

// File: logic/cache_ctrl.sv
/*
 Decodes the request against the lookup result and drives the array enables.
 Holds the only response register. Funct3 values outside RV32I do no load or store.
*/
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  cache_pkg::cache_op_t   op,
    input  cache_pkg::mem_width_t  width,
    input  cache_pkg::way_onehot_t hit_ways,
    input  cache_pkg::way_index_t  victim_way,
    input  logic                   sel_valid,
    input  logic                   sel_dirty,
    input  cache_pkg::tag_t        sel_tag,
    input  cache_pkg::word_t       load_data,
    output cache_pkg::way_index_t  target_way,
    output logic                   tag_we,
    output logic                   data_we,
    output logic                   dirty_set,
    output logic                   touch,
    output logic                   rsp_valid,
    output logic                   hit,
    output logic                   victim_valid,
    output logic                   victim_dirty,
    output cache_pkg::word_t       rdata,
    output cache_pkg::tag_t        victim_tag
);

    logic                  any_hit;
    logic                  width_ok;
    logic                  load_hit;
    logic                  store_hit;
    logic                  is_fill;
    cache_pkg::way_index_t hit_way;

    // one-hot to index, hit_ways has at most one bit set
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            if (hit_ways[i]) hit_way = cache_pkg::way_index_t'(i);
        end
    end

    assign any_hit  = |hit_ways;
    assign width_ok = width inside {cache_pkg::width_b, cache_pkg::width_h, cache_pkg::width_w,
                                    cache_pkg::width_bu, cache_pkg::width_hu};

    assign is_fill   = (op == cache_pkg::op_fill);
    assign load_hit  = (op == cache_pkg::op_load) && any_hit && width_ok;
    assign store_hit = (op == cache_pkg::op_store) && any_hit && width_ok;

    assign target_way = any_hit ? hit_way : victim_way;  // victim only on miss
    assign tag_we     = is_fill;
    assign data_we    = store_hit || is_fill;
    assign dirty_set  = store_hit;
    assign touch      = load_hit || store_hit || is_fill;  // misses leave tree alone

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (op != cache_pkg::op_none);
        end
    end

    // response payload, state seen before this edge's update
    always_ff @(posedge clk) begin
        hit          <= any_hit;
        rdata        <= load_hit ? load_data : '0;
        victim_valid <= sel_valid;
        victim_dirty <= sel_dirty;
        victim_tag   <= sel_tag;
    end

endmodule

// File: logic/cache_top.sv
/*
 4-way set-associative data cache, one request per cycle, no stall.
 Responses are registered and come one cycle after the request edge.
*/
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_top (
    input  logic                   clk,
    input  logic                   reset,
    input  cache_pkg::cache_op_t   op,
    input  logic [31:0]            addr,
    input  cache_pkg::mem_width_t  width,
    input  cache_pkg::word_t       wdata,
    output logic                   rsp_valid,
    output logic                   hit,
    output cache_pkg::word_t       rdata,
    output logic                   victim_valid,
    output logic                   victim_dirty,
    output cache_pkg::tag_t        victim_tag
);

    localparam int OFS_BITS = `CACHE_WORD_BITS + `CACHE_BYTE_BITS;

    cache_pkg::tag_t                addr_tag;
    cache_pkg::set_index_t          set_index;
    logic [`CACHE_WORD_BITS-1:0]    word_offset;
    logic [`CACHE_BYTE_BITS-1:0]    byte_offset;

    cache_pkg::way_onehot_t         hit_ways;
    cache_pkg::way_onehot_t         valid_ways;
    cache_pkg::way_index_t          victim_way;
    cache_pkg::way_index_t          target_way;
    logic                           sel_valid;
    logic                           sel_dirty;
    cache_pkg::tag_t                sel_tag;
    logic                           tag_we;
    logic                           data_we;
    logic                           dirty_set;
    logic                           touch;
    cache_pkg::word_t               rd_word;
    cache_pkg::word_t               wr_word;
    cache_pkg::word_t               load_data;

    // tag | index | word | byte
    assign addr_tag    = addr[31 -: `CACHE_TAG_BITS];
    assign set_index   = addr[OFS_BITS +: `CACHE_INDEX_BITS];
    assign word_offset = addr[`CACHE_BYTE_BITS +: `CACHE_WORD_BITS];
    assign byte_offset = addr[`CACHE_BYTE_BITS-1:0];

    cache_ctrl cache_ctrl_inst (
        .clk(clk), .reset(reset), .op(op), .width(width),
        .hit_ways(hit_ways), .victim_way(victim_way),
        .sel_valid(sel_valid), .sel_dirty(sel_dirty), .sel_tag(sel_tag),
        .load_data(load_data), .target_way(target_way),
        .tag_we(tag_we), .data_we(data_we), .dirty_set(dirty_set), .touch(touch),
        .rsp_valid(rsp_valid), .hit(hit), .victim_valid(victim_valid),
        .victim_dirty(victim_dirty), .rdata(rdata), .victim_tag(victim_tag)
    );

    tag_store tag_store_inst (
        .clk(clk), .reset(reset), .set_index(set_index), .addr_tag(addr_tag),
        .target_way(target_way), .tag_we(tag_we), .dirty_set(dirty_set),
        .hit_ways(hit_ways), .valid_ways(valid_ways),
        .sel_valid(sel_valid), .sel_dirty(sel_dirty), .sel_tag(sel_tag)
    );

    data_store data_store_inst (
        .clk(clk), .set_index(set_index), .word_offset(word_offset),
        .target_way(target_way), .data_we(data_we), .wr_word(wr_word), .rd_word(rd_word)
    );

    plru_tree plru_tree_inst (
        .clk(clk), .reset(reset), .set_index(set_index), .valid_ways(valid_ways),
        .touch(touch), .target_way(target_way), .victim_way(victim_way)
    );

    byte_lane_unit byte_lane_unit_inst (
        .op(op), .width(width), .byte_offset(byte_offset), .old_word(rd_word),
        .wdata(wdata), .load_data(load_data), .wr_word(wr_word)
    );

endmodule

// File: tests/cache_tb.sv
/*
 Random and directed requests against a behavioral cache model.
 Victim tags are only checked when the reported way is valid.
*/
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_tb;

    logic                  clk;
    logic                  reset;
    cache_pkg::cache_op_t  op;
    logic [31:0]           addr;
    cache_pkg::mem_width_t width;
    cache_pkg::word_t      wdata;
    logic                  rsp_valid;
    logic                  hit;
    cache_pkg::word_t      rdata;
    logic                  victim_valid;
    logic                  victim_dirty;
    cache_pkg::tag_t       victim_tag;

    // behavioral model state
    logic [23:0] m_tag   [`CACHE_SETS][`CACHE_WAYS];
    logic        m_valid [`CACHE_SETS][`CACHE_WAYS];
    logic        m_dirty [`CACHE_SETS][`CACHE_WAYS];
    logic [31:0] m_data  [`CACHE_SETS][`CACHE_WAYS][`CACHE_LINE_WORDS];
    logic [2:0]  m_tree  [`CACHE_SETS];

    logic [31:0] rng = 32'he583_e4a2;
    int          errors = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    logic        timed_out = 1'b0;

    cache_top cache_top_inst (
        .clk(clk), .reset(reset), .op(op), .addr(addr), .width(width), .wdata(wdata),
        .rsp_valid(rsp_valid), .hit(hit), .rdata(rdata), .victim_valid(victim_valid),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge timed_out) begin
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] load_value(logic [31:0] w, cache_pkg::mem_width_t wd,
                                               logic [1:0] off);
        logic [31:0] sh;
        logic [7:0]  b;
        logic [15:0] h;
        sh = w >> (off * 8);
        b = sh[7:0];
        sh = w >> (off[1] * 16);
        h = sh[15:0];
        case (wd)
            cache_pkg::width_b:  return {{24{b[7]}}, b};
            cache_pkg::width_h:  return {{16{h[15]}}, h};
            cache_pkg::width_bu: return {24'h0, b};
            cache_pkg::width_hu: return {16'h0, h};
            default:             return w;
        endcase
    endfunction

    function automatic logic [31:0] store_merge(logic [31:0] w, logic [31:0] d,
                                                cache_pkg::mem_width_t wd, logic [1:0] off);
        logic [31:0] r;
        r = w;
        if (wd == cache_pkg::width_b || wd == cache_pkg::width_bu) begin
            r = (w & ~(32'hff << (off * 8))) | ({24'h0, d[7:0]} << (off * 8));
        end else if (wd == cache_pkg::width_h || wd == cache_pkg::width_hu) begin
            if (off[1]) r[31:16] = d[15:0];
            else r[15:0] = d[15:0];
        end else r = d;
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic clear_model();
        for (int s = 0; s < `CACHE_SETS; s++) begin
            m_tree[s] = 3'b000;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        op = cache_pkg::op_none;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        clear_model();
    endtask

    // called on a falling edge, returns on the falling edge after the response
    task automatic request(input cache_pkg::cache_op_t o, input logic [31:0] a,
                           input cache_pkg::mem_width_t wd, input logic [31:0] d);
        int          s;
        int          wo;
        int          hw;
        int          tw;
        int          guard;
        logic [23:0] t;
        logic [31:0] exp_rdata;
        logic        exp_hit;
        s = int'(a[7:4]);
        wo = int'(a[3:2]);
        t = a[31:8];
        hw = -1;
        tw = -1;
        for (int w = 0; w < `CACHE_WAYS; w++)
            if (m_valid[s][w] && m_tag[s][w] == t) hw = w;
        exp_hit = (hw >= 0);
        for (int w = `CACHE_WAYS - 1; w >= 0; w--)
            if (!m_valid[s][w]) tw = w;
        if (tw < 0) tw = !m_tree[s][0] ? (m_tree[s][2] ? 1 : 0) : (m_tree[s][1] ? 3 : 2);
        if (exp_hit) tw = hw;
        exp_rdata = (exp_hit && o == cache_pkg::op_load) ?
                    load_value(m_data[s][tw][wo], wd, a[1:0]) : 32'h0;
        op = o;
        addr = a;
        width = wd;
        wdata = d;
        @(posedge clk);
        @(negedge clk);
        op = cache_pkg::op_none;
        guard = 0;
        while (!rsp_valid && guard < 8) begin
            @(negedge clk);
            guard++;
        end
        if (!rsp_valid) begin
            $display("no response from the cache within 8 cycles at %0t ns", $time);
            timed_out = 1'b1;
        end else begin
            assert (guard == 0) else begin
                $display("response came %0d cycles late at %0t ns", guard, $time);
                errors++;
            end
            check_field("hit", {31'b0, exp_hit}, {31'b0, hit});
            check_field("rdata", exp_rdata, rdata);
            check_field("victim_valid", {31'b0, m_valid[s][tw]}, {31'b0, victim_valid});
            check_field("victim_dirty", {31'b0, m_dirty[s][tw]}, {31'b0, victim_dirty});
            if (m_valid[s][tw]) begin
                check_field("victim_tag", {8'h0, m_tag[s][tw]}, {8'h0, victim_tag});
            end
        end
        // model update after the lookup
        if (o == cache_pkg::op_fill || (exp_hit && o != cache_pkg::op_none)) begin
            m_tree[s][0] = ~tw[1];
            if (tw[1]) m_tree[s][1] = ~tw[0];
            else m_tree[s][2] = ~tw[0];
        end
        if (o == cache_pkg::op_fill) begin
            m_data[s][tw][wo] = d;
            m_tag[s][tw] = t;
            m_valid[s][tw] = 1'b1;
            m_dirty[s][tw] = 1'b0;
        end else if (o == cache_pkg::op_store && exp_hit) begin
            m_data[s][tw][wo] = store_merge(m_data[s][tw][wo], d, wd, a[1:0]);
            m_dirty[s][tw] = 1'b1;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        logic [31:0] fills [8];
        logic [31:0] base;
        logic [31:0] rnd;
        logic [23:0] tags [4];
        int          e0;
        cache_pkg::mem_width_t wl [4];
        cache_pkg::mem_width_t ws [3];
        wl = '{cache_pkg::width_b, cache_pkg::width_h, cache_pkg::width_bu, cache_pkg::width_hu};
        ws = '{cache_pkg::width_b, cache_pkg::width_h, cache_pkg::width_w};
        reset = 1'b1;
        op = cache_pkg::op_none;
        addr = '0;
        width = cache_pkg::width_w;
        wdata = '0;
        @(negedge clk);
        apply_reset();

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            request(cache_pkg::op_load, next_rand(), cache_pkg::width_w, 32'h0);
            check_field("victim_valid", 32'h0, {31'b0, victim_valid});
            @(negedge clk);
            check_field("rsp_valid", 32'h0, {31'b0, rsp_valid});  // single pulse
        end
        finish_test("reset_state", e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            fills[i] = next_rand() & 32'hffff_fffc;
            request(cache_pkg::op_fill, fills[i], cache_pkg::width_w, next_rand());
        end
        for (int i = 0; i < 8; i++) request(cache_pkg::op_load, fills[i], cache_pkg::width_w, 0);
        // fill set 5 so a missed store would land on a valid line
        for (int i = 0; i < 4; i++) begin
            rnd = next_rand();
            fills[i] = {rnd[31:8], 8'h50};
            request(cache_pkg::op_fill, fills[i], cache_pkg::width_w, next_rand());
        end
        base = {24'hfff_ffe, 8'h50};
        request(cache_pkg::op_load, base, cache_pkg::width_w, 32'h0);
        request(cache_pkg::op_store, base, cache_pkg::width_w, next_rand());
        request(cache_pkg::op_load, base, cache_pkg::width_w, 32'h0);
        for (int i = 0; i < 4; i++) request(cache_pkg::op_load, fills[i], cache_pkg::width_w, 0);
        finish_test("fill_and_miss", e0);

        e0 = errors;
        base = next_rand() & 32'hffff_fff0;
        request(cache_pkg::op_fill, base, cache_pkg::width_w, 32'h80f7_7f01);
        for (int w = 0; w < 4; w++)
            for (int o = 0; o < 4; o++) request(cache_pkg::op_load, base + o, wl[w], 32'h0);
        finish_test("load_widths", e0);

        e0 = errors;
        for (int w = 0; w < 3; w++) begin
            for (int o = 0; o < 4; o++) begin
                request(cache_pkg::op_store, base + o, ws[w], next_rand());
                request(cache_pkg::op_load, base, cache_pkg::width_w, 32'h0);
                check_field("victim_dirty", 32'h1, {31'b0, victim_dirty});
            end
        end
        request(cache_pkg::op_fill, base, cache_pkg::width_w, next_rand());
        request(cache_pkg::op_load, base, cache_pkg::width_w, 32'h0);
        check_field("victim_dirty", 32'h0, {31'b0, victim_dirty});
        finish_test("store_merge", e0);

        e0 = errors;
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            rnd = next_rand();
            tags[i] = {rnd[23:4], 4'(i)};
            request(cache_pkg::op_fill, {tags[i], 8'h94}, cache_pkg::width_w, next_rand());
        end
        request(cache_pkg::op_load, {tags[2], 8'h94}, cache_pkg::width_w, 32'h0);
        request(cache_pkg::op_load, {tags[0], 8'h94}, cache_pkg::width_w, 32'h0);
        request(cache_pkg::op_load, {tags[3], 8'h94}, cache_pkg::width_w, 32'h0);
        request(cache_pkg::op_load, {tags[1], 8'h94}, cache_pkg::width_w, 32'h0);
        request(cache_pkg::op_fill, {24'h0bad_00, 8'h94}, cache_pkg::width_w, next_rand());
        check_field("victim_valid", 32'h1, {31'b0, victim_valid});
        for (int i = 0; i < 4; i++) begin
            request(cache_pkg::op_load, {tags[i], 8'h94}, cache_pkg::width_w, 32'h0);
            check_field("hit", (i == 2) ? 32'h0 : 32'h1, {31'b0, hit});
        end
        finish_test("replacement", e0);

        $display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+logic
logic/cache_pkg.sv
logic/byte_lane_unit.sv
logic/data_store.sv
logic/tag_store.sv
logic/plru_tree.sv
logic/cache_ctrl.sv
logic/cache_top.sv
tests/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator; fails if the log holds the fail message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Ilogic -f compile.f \
    --top-module cache_tb -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
